// File: audio_fx_pkg.sv
/*
 * Shared types and constants for the stereo post-processing chain.
 * Holds the sample and beat structs, the configuration word, the
 * Wishbone request and response bundles and the register map.
 */

package audio_fx_pkg;

    // ==============================
    // Sample and beat types
    // ==============================

    localparam int sample_width = 32;

    typedef logic signed [sample_width-1:0] audio_sample_t;

    typedef struct packed {
        audio_sample_t left;
        audio_sample_t right;
    } stereo_t;

    // One datapath hop, data plus qualifier
    typedef struct packed {
        stereo_t data;
        logic    valid;
    } stereo_beat_t;

    typedef logic [15:0] gain_t;

    // ==============================
    // Configuration word
    // ==============================

    typedef struct packed {
        logic  bass_en;
        logic  widen_en;
        logic  dynamics_en;
        logic  clarity_en;
        logic  streams_en;
        logic  s1_en;
        logic  s2_en;
        logic  s3_en;
        gain_t bass_gain;   // Q4.12
        gain_t width;       // Q0.16
    } fx_cfg_t;

    // Wishbone classic, word addressed
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        reg_ctrl         = 4'd0,
        reg_bass_gain    = 4'd1,
        reg_width        = 4'd2,
        reg_sample_count = 4'd3
    } reg_addr_e;

    // ==============================
    // Constants
    // ==============================

    localparam gain_t bass_gain_reset = 16'h1000;
    localparam gain_t width_reset     = 16'h0800;

    localparam int bass_shift         = 12;
    localparam int width_shift        = 16;
    localparam int dynamics_shift     = 4;
    localparam int clarity_shift      = 8;
    localparam int line_atten_shift   = 2;   // -12 dB
    localparam int phones_boost_shift = 1;   // +6 dB

    // Input beat to main and stream outputs
    localparam int fx_latency = 5;

endpackage

// File: audio_fx_regs.sv
/*
 * Configuration register block behind a Wishbone classic slave.
 * Acks one cycle after a request, commits writes one cycle after the ack
 * and counts samples delivered on the main output.
 */

`timescale 1ns/10ps

module audio_fx_regs (
    input  logic                  clk_dac_hs,
    input  logic                  rst_n,
    input  audio_fx_pkg::wb_req_t wb_req,
    output audio_fx_pkg::wb_rsp_t wb_rsp,
    input  logic                  delivered,
    output audio_fx_pkg::fx_cfg_t cfg
);
    import audio_fx_pkg::*;

    logic [7:0]  ctrl_q;
    gain_t       bass_gain_q;
    gain_t       width_q;
    logic [31:0] sample_count_q;

    logic        req;
    logic        ack_q;
    logic [31:0] rd_mux;
    logic [31:0] rd_dat_q;
    logic        wr_pend_q;
    logic [3:0]  wr_adr_q;
    logic [31:0] wr_dat_q;

    assign req = wb_req.cyc && wb_req.stb;

    // Read data for the address on the bus
    always_comb begin
        case (reg_addr_e'(wb_req.adr))
            reg_ctrl:         rd_mux = {24'b0, ctrl_q};
            reg_bass_gain:    rd_mux = {16'b0, bass_gain_q};
            reg_width:        rd_mux = {16'b0, width_q};
            reg_sample_count: rd_mux = sample_count_q;
            default:          rd_mux = '0;
        endcase
    end

    // Single-cycle ack, never back to back
    always_ff @(posedge clk_dac_hs or negedge rst_n) begin
        if (!rst_n) begin
            ack_q     <= 1'b0;
            wr_pend_q <= 1'b0;
            rd_dat_q  <= '0;
        end else begin
            ack_q     <= req && !ack_q;
            wr_pend_q <= req && !ack_q && wb_req.we;
            if (req && !ack_q) begin
                rd_dat_q <= rd_mux;
            end
        end
    end

    // Write address and data held until commit
    always_ff @(posedge clk_dac_hs) begin
        if (req && !ack_q) begin
            wr_adr_q <= wb_req.adr;
            wr_dat_q <= wb_req.dat;
        end
    end

    always_ff @(posedge clk_dac_hs or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q         <= '0;
            bass_gain_q    <= bass_gain_reset;
            width_q        <= width_reset;
            sample_count_q <= '0;
        end else begin
            if (wr_pend_q) begin
                case (reg_addr_e'(wr_adr_q))
                    reg_ctrl:      ctrl_q      <= wr_dat_q[7:0];
                    reg_bass_gain: bass_gain_q <= wr_dat_q[15:0];
                    reg_width:     width_q     <= wr_dat_q[15:0];
                    default:       ;
                endcase
            end
            // Free-running, wraps at 2^32
            if (delivered) begin
                sample_count_q <= sample_count_q + 32'd1;
            end
        end
    end

    always_comb begin
        wb_rsp.dat      = rd_dat_q;
        wb_rsp.ack      = ack_q;
        cfg.bass_en     = ctrl_q[0];
        cfg.widen_en    = ctrl_q[1];
        cfg.dynamics_en = ctrl_q[2];
        cfg.clarity_en  = ctrl_q[3];
        cfg.streams_en  = ctrl_q[4];
        cfg.s1_en       = ctrl_q[5];
        cfg.s2_en       = ctrl_q[6];
        cfg.s3_en       = ctrl_q[7];
        cfg.bass_gain   = bass_gain_q;
        cfg.width       = width_q;
    end

endmodule

// File: audio_fx_effects.sv
/*
 * Effects stage: bass gain followed by stereo widening.
 * Two registers deep and every beat passes through both.
 */

`timescale 1ns/10ps

module audio_fx_effects (
    input  logic                       clk_dac_hs,
    input  logic                       rst_n,
    input  audio_fx_pkg::fx_cfg_t      cfg,
    input  audio_fx_pkg::stereo_beat_t beat_in,
    output audio_fx_pkg::stereo_beat_t beat_out
);
    import audio_fx_pkg::*;

    stereo_beat_t bass_q;
    stereo_beat_t widen_q;

    // Unsigned Q4.12 gain on a signed sample
    function automatic audio_sample_t bass_scale(audio_sample_t s, gain_t g);
        logic signed [63:0] s_ext;
        logic signed [63:0] g_ext;
        logic signed [63:0] prod;
        s_ext = s;
        g_ext = {48'b0, g};
        prod  = (s_ext * g_ext) >>> bass_shift;
        return prod[31:0];
    endfunction

    // Own channel plus scaled side signal
    function automatic audio_sample_t widen(audio_sample_t a, audio_sample_t b, gain_t w);
        logic signed [63:0] a_ext;
        logic signed [63:0] b_ext;
        logic signed [63:0] w_ext;
        logic signed [63:0] side;
        logic signed [63:0] sum;
        a_ext = a;
        b_ext = b;
        w_ext = {48'b0, w};
        side  = ((a_ext - b_ext) * w_ext) >>> width_shift;
        sum   = a_ext + side;
        return sum[31:0];
    endfunction

    always_ff @(posedge clk_dac_hs or negedge rst_n) begin
        if (!rst_n) begin
            bass_q  <= '0;
            widen_q <= '0;
        end else begin
            // Stage 1 bass gain
            bass_q.valid <= beat_in.valid;
            if (cfg.bass_en) begin
                bass_q.data.left  <= bass_scale(beat_in.data.left, cfg.bass_gain);
                bass_q.data.right <= bass_scale(beat_in.data.right, cfg.bass_gain);
            end else begin
                bass_q.data <= beat_in.data;
            end

            // Stage 2 widening
            widen_q.valid <= bass_q.valid;
            if (cfg.widen_en) begin
                widen_q.data.left  <= widen(bass_q.data.left, bass_q.data.right, cfg.width);
                widen_q.data.right <= widen(bass_q.data.right, bass_q.data.left, cfg.width);
            end else begin
                widen_q.data <= bass_q.data;
            end
        end
    end

    assign beat_out = widen_q;

endmodule

// File: audio_fx_enhancer.sv
/*
 * Enhancement stage: dynamics expansion then clarity emphasis.
 * Both add a shifted copy of the sample to itself, wrapping at 32 bits.
 */

`timescale 1ns/10ps

module audio_fx_enhancer (
    input  logic                       clk_dac_hs,
    input  logic                       rst_n,
    input  audio_fx_pkg::fx_cfg_t      cfg,
    input  audio_fx_pkg::stereo_beat_t beat_in,
    output audio_fx_pkg::stereo_beat_t beat_out
);
    import audio_fx_pkg::*;

    stereo_beat_t dyn_q;
    stereo_beat_t clar_q;

    function automatic stereo_t emphasize(stereo_t s, int unsigned sh);
        stereo_t r;
        r.left  = s.left + (s.left >>> sh);
        r.right = s.right + (s.right >>> sh);
        return r;
    endfunction

    always_ff @(posedge clk_dac_hs or negedge rst_n) begin
        if (!rst_n) begin
            dyn_q  <= '0;
            clar_q <= '0;
        end else begin
            dyn_q.valid  <= beat_in.valid;
            clar_q.valid <= dyn_q.valid;

            // Dynamics expansion, about +0.5 dB
            if (cfg.dynamics_en) begin
                dyn_q.data <= emphasize(beat_in.data, dynamics_shift);
            end else begin
                dyn_q.data <= beat_in.data;
            end

            // Clarity emphasis
            if (cfg.clarity_en) begin
                clar_q.data <= emphasize(dyn_q.data, clarity_shift);
            end else begin
                clar_q.data <= dyn_q.data;
            end
        end
    end

    assign beat_out = clar_q;

endmodule

// File: audio_fx_streams.sv
/*
 * Output stage. Registers the main enhanced output and three derived
 * streams: full range, line level at -12 dB and headphone level at +6 dB.
 * Also flags each delivered main-output sample to the register block.
 */

`timescale 1ns/10ps

module audio_fx_streams (
    input  logic                       clk_dac_hs,
    input  logic                       rst_n,
    input  audio_fx_pkg::fx_cfg_t      cfg,
    input  audio_fx_pkg::stereo_beat_t beat_in,
    output audio_fx_pkg::stereo_beat_t main_out,
    output audio_fx_pkg::stereo_beat_t stream1_out,
    output audio_fx_pkg::stereo_beat_t stream2_out,
    output audio_fx_pkg::stereo_beat_t stream3_out,
    output logic                       delivered
);
    import audio_fx_pkg::*;

    stereo_beat_t main_q;
    stereo_beat_t stream_q [3];
    stereo_t      stream_d [3];
    logic [2:0]   stream_en;

    // Stream n fires only with a beat and both enables
    assign stream_en = {cfg.s3_en, cfg.s2_en, cfg.s1_en}
                     & {3{cfg.streams_en && beat_in.valid}};

    always_comb begin
        stream_d[0]       = beat_in.data;
        stream_d[1].left  = beat_in.data.left >>> line_atten_shift;
        stream_d[1].right = beat_in.data.right >>> line_atten_shift;
        // Boost wraps on overflow
        stream_d[2].left  = beat_in.data.left <<< phones_boost_shift;
        stream_d[2].right = beat_in.data.right <<< phones_boost_shift;
    end

    always_ff @(posedge clk_dac_hs or negedge rst_n) begin
        if (!rst_n) begin
            main_q <= '0;
            for (int i = 0; i < 3; i++) begin
                stream_q[i] <= '0;
            end
        end else begin
            main_q <= beat_in;
            for (int i = 0; i < 3; i++) begin
                stream_q[i].valid <= stream_en[i];
                // Data holds while the stream is idle
                if (stream_en[i]) begin
                    stream_q[i].data <= stream_d[i];
                end
            end
        end
    end

    assign main_out    = main_q;
    assign stream1_out = stream_q[0];
    assign stream2_out = stream_q[1];
    assign stream3_out = stream_q[2];
    assign delivered   = main_q.valid;

endmodule

// File: audio_fx_top.sv
/*
 * Top level of the DAC post-processing chain.
 * Wishbone configures the register block, audio flows effects, enhancer,
 * streams with a fixed five-cycle latency and no back-pressure.
 */

`timescale 1ns/10ps

module audio_fx_top (
    input  logic                       clk_dac_hs,
    input  logic                       rst_n,
    input  audio_fx_pkg::wb_req_t      wb_req,
    output audio_fx_pkg::wb_rsp_t      wb_rsp,
    input  audio_fx_pkg::stereo_beat_t audio_in,
    output audio_fx_pkg::stereo_beat_t main_out,
    output audio_fx_pkg::stereo_beat_t stream1_out,
    output audio_fx_pkg::stereo_beat_t stream2_out,
    output audio_fx_pkg::stereo_beat_t stream3_out
);
    import audio_fx_pkg::*;

    fx_cfg_t      cfg;
    stereo_beat_t fx_beat;
    stereo_beat_t enh_beat;
    logic         delivered;

    // ==============================
    // Configuration
    // ==============================

    audio_fx_regs u_regs (
        .clk_dac_hs (clk_dac_hs),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .delivered  (delivered),
        .cfg        (cfg)
    );

    // ==============================
    // Datapath
    // ==============================

    // 2 cycles
    audio_fx_effects u_effects (
        .clk_dac_hs (clk_dac_hs),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .beat_in    (audio_in),
        .beat_out   (fx_beat)
    );

    // 2 cycles
    audio_fx_enhancer u_enhancer (
        .clk_dac_hs (clk_dac_hs),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .beat_in    (fx_beat),
        .beat_out   (enh_beat)
    );

    // 1 cycle
    audio_fx_streams u_streams (
        .clk_dac_hs  (clk_dac_hs),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .beat_in     (enh_beat),
        .main_out    (main_out),
        .stream1_out (stream1_out),
        .stream2_out (stream2_out),
        .stream3_out (stream3_out),
        .delivered   (delivered)
    );

endmodule

// File: audio_fx_chk.sv
/*
 * Assertions on the top level ports, bound into audio_fx_top.
 * Covers the Wishbone ack pulse and the audio valid timing.
 */

`timescale 1ns/10ps

module audio_fx_chk (
    input logic                       clk_dac_hs,
    input logic                       rst_n,
    input audio_fx_pkg::wb_req_t      wb_req,
    input audio_fx_pkg::wb_rsp_t      wb_rsp,
    input audio_fx_pkg::stereo_beat_t audio_in,
    input audio_fx_pkg::stereo_beat_t main_out,
    input audio_fx_pkg::stereo_beat_t stream1_out,
    input audio_fx_pkg::stereo_beat_t stream2_out,
    input audio_fx_pkg::stereo_beat_t stream3_out
);
    import audio_fx_pkg::*;

    // Running count of assertion failures
    int unsigned fail_count = 0;

    // Ack is a single pulse
    a_ack_single: assert property (@(posedge clk_dac_hs) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_count++;
            $error("ack high on two consecutive cycles");
        end

    a_ack_req: assert property (@(posedge clk_dac_hs) disable iff (!rst_n)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            fail_count++;
            $error("ack rose without a request");
        end

    a_latency: assert property (@(posedge clk_dac_hs) disable iff (!rst_n)
        main_out.valid == $past(audio_in.valid, fx_latency))
        else begin
            fail_count++;
            $error("main_out valid out of step with input");
        end

    a_stream_main: assert property (@(posedge clk_dac_hs) disable iff (!rst_n)
        (stream1_out.valid || stream2_out.valid || stream3_out.valid) |-> main_out.valid)
        else begin
            fail_count++;
            $error("stream valid without main_out valid");
        end

endmodule

bind audio_fx_top audio_fx_chk u_chk (.*);

// File: audio_fx_tb.sv
/*
 * Testbench for the stereo post-processing chain.
 * Drives random beats and Wishbone accesses on the falling edge and checks
 * every output against a reference model held in a queue of expected beats.
 */

`timescale 1ns/10ps

module audio_fx_tb;
    import audio_fx_pkg::*;

    typedef struct packed {
        stereo_beat_t main;
        stereo_beat_t s1;
        stereo_beat_t s2;
        stereo_beat_t s3;
    } expect_t;

    logic         clk_dac_hs;
    logic         rst_n;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    stereo_beat_t audio_in;
    stereo_beat_t main_out;
    stereo_beat_t stream1_out;
    stereo_beat_t stream2_out;
    stereo_beat_t stream3_out;

    fx_cfg_t      cfg_m;
    expect_t      exp_q [$];
    int unsigned  lcg_state = 97505;
    int unsigned  beats_sent;
    logic [31:0]  rd_val;

    audio_fx_top u_audio_fx_top (.*);

    initial begin
        clk_dac_hs = 1'b0;
        forever #5 clk_dac_hs = ~clk_dac_hs;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_equal(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "%s", msg);
    endtask

    // Stop at the first bound assertion failure
    always @(negedge clk_dac_hs) begin
        if (u_audio_fx_top.u_chk.fail_count != 0) begin
            abort_run("A bound assertion on the DUT ports failed");
        end
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic audio_sample_t bass_model(audio_sample_t s, gain_t g);
        longint sl;
        longint gl;
        longint p;
        sl = s;
        gl = g;
        p  = (sl * gl) >>> bass_shift;
        return p[31:0];
    endfunction

    function automatic audio_sample_t widen_model(audio_sample_t a, audio_sample_t b, gain_t w);
        longint al;
        longint bl;
        longint wl;
        longint p;
        al = a;
        bl = b;
        wl = w;
        p  = al + (((al - bl) * wl) >>> width_shift);
        return p[31:0];
    endfunction

    // Sample plus a scaled-down copy of itself
    function automatic audio_sample_t add_shifted(audio_sample_t s, int sh);
        longint sl;
        longint p;
        sl = s;
        p  = sl + (sl >>> sh);
        return p[31:0];
    endfunction

    function automatic expect_t model_beat(stereo_beat_t b, fx_cfg_t c);
        expect_t       e;
        audio_sample_t l;
        audio_sample_t r;
        audio_sample_t t;
        l = b.data.left;
        r = b.data.right;
        if (c.bass_en) begin
            l = bass_model(l, c.bass_gain);
            r = bass_model(r, c.bass_gain);
        end
        if (c.widen_en) begin
            t = widen_model(l, r, c.width);
            r = widen_model(r, l, c.width);
            l = t;
        end
        if (c.dynamics_en) begin
            l = add_shifted(l, dynamics_shift);
            r = add_shifted(r, dynamics_shift);
        end
        if (c.clarity_en) begin
            l = add_shifted(l, clarity_shift);
            r = add_shifted(r, clarity_shift);
        end
        e.main.valid      = b.valid;
        e.main.data.left  = l;
        e.main.data.right = r;
        e.s1.valid        = b.valid && c.streams_en && c.s1_en;
        e.s1.data         = e.main.data;
        e.s2.valid        = b.valid && c.streams_en && c.s2_en;
        e.s2.data.left    = l >>> line_atten_shift;
        e.s2.data.right   = r >>> line_atten_shift;
        e.s3.valid        = b.valid && c.streams_en && c.s3_en;
        e.s3.data.left    = l <<< phones_boost_shift;
        e.s3.data.right   = r <<< phones_boost_shift;
        return e;
    endfunction

    // ==============================
    // Stimulus
    // ==============================

    task automatic compare_beat(string name, stereo_beat_t e, stereo_beat_t a);
        check_equal({name, ".valid"}, e.valid, a.valid);
        if (e.valid) begin
            check_equal({name, ".data"}, e.data, a.data);
        end
    endtask

    // One clock of the datapath; outputs are due fx_latency steps later
    task automatic step(stereo_beat_t b);
        expect_t e;
        @(negedge clk_dac_hs);
        if (exp_q.size() == fx_latency) begin
            e = exp_q.pop_front();
            compare_beat("main_out", e.main, main_out);
            compare_beat("stream1_out", e.s1, stream1_out);
            compare_beat("stream2_out", e.s2, stream2_out);
            compare_beat("stream3_out", e.s3, stream3_out);
        end
        audio_in = b;
        if (b.valid) begin
            beats_sent++;
        end
        exp_q.push_back(model_beat(b, cfg_m));
    endtask

    task automatic random_beats(int n);
        stereo_beat_t b;
        logic [31:0]  r;
        for (int i = 0; i < n; i++) begin
            r            = lcg_next();
            b.valid      = (r[31:30] != 2'b00);
            b.data.left  = lcg_next();
            b.data.right = lcg_next();
            step(b);
        end
        // Flush so only idle entries remain
        repeat (fx_latency) step('0);
        exp_q.delete();
    endtask

    task automatic wb_access(logic we, logic [3:0] adr, logic [31:0] dat,
                             output logic [31:0] rdat);
        bit acked;
        acked = 1'b0;
        rdat  = '0;
        @(negedge clk_dac_hs);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        for (int i = 0; i < 20 && !acked; i++) begin
            @(negedge clk_dac_hs);
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        wb_req = '0;
        if (!acked) begin
            abort_run("Wishbone access timed out without an ack");
        end
        // Register commit lands one cycle after ack
        @(negedge clk_dac_hs);
    endtask

    task automatic read_expect(logic [3:0] adr, logic [31:0] exp, string name);
        logic [31:0] v;
        wb_access(1'b0, adr, '0, v);
        check_equal(name, exp, v);
    endtask

    task automatic set_ctrl(logic [7:0] ctrl);
        wb_access(1'b1, reg_ctrl, {24'b0, ctrl}, rd_val);
        {cfg_m.s3_en, cfg_m.s2_en, cfg_m.s1_en, cfg_m.streams_en,
         cfg_m.clarity_en, cfg_m.dynamics_en, cfg_m.widen_en, cfg_m.bass_en} = ctrl;
    endtask

    task automatic set_gains(logic [15:0] g, logic [15:0] w);
        wb_access(1'b1, reg_bass_gain, {16'b0, g}, rd_val);
        wb_access(1'b1, reg_width, {16'b0, w}, rd_val);
        cfg_m.bass_gain = g;
        cfg_m.width     = w;
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        rst_n           = 1'b0;
        wb_req          = '0;
        audio_in        = '0;
        beats_sent      = 0;
        cfg_m           = '0;
        cfg_m.bass_gain = bass_gain_reset;
        cfg_m.width     = width_reset;
        repeat (5) @(negedge clk_dac_hs);
        rst_n = 1'b1;

        // Reset values and read-only counter
        read_expect(reg_ctrl, 32'h0, "reg_ctrl");
        read_expect(reg_bass_gain, {16'b0, bass_gain_reset}, "reg_bass_gain");
        read_expect(reg_width, {16'b0, width_reset}, "reg_width");
        read_expect(reg_sample_count, 32'h0, "reg_sample_count");
        read_expect(4'hA, 32'h0, "unmapped register");
        wb_access(1'b1, reg_sample_count, 32'hDEAD_BEEF, rd_val);
        read_expect(reg_sample_count, 32'h0, "reg_sample_count");

        random_beats(200);

        // Every combination of the four effect enables
        // Stream enables random while streams_en stays low
        for (int combo = 0; combo < 16; combo++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            set_gains(r1[31:16], r2[31:16]);
            set_ctrl({r1[15:13], 1'b0, 4'(combo)});
            random_beats(100);
        end

        // Stream enable sweep on top of random effects
        for (int sel = 0; sel < 8; sel++) begin
            r1 = lcg_next();
            set_ctrl({3'(sel), 1'b1, r1[31:28]});
            random_beats(60);
        end

        read_expect(reg_sample_count, beats_sent, "reg_sample_count");

        if (u_audio_fx_top.u_chk.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("A bound assertion on the DUT ports failed");
        end
    end

endmodule

// File: audio_fx_top.f
audio_fx_pkg.sv
audio_fx_regs.sv
audio_fx_effects.sv
audio_fx_enhancer.sv
audio_fx_streams.sv
audio_fx_top.sv
audio_fx_chk.sv
audio_fx_tb.sv

// File: Bender.yml
package:
  name: audio_fx

sources:
  - files:
      - audio_fx_pkg.sv
      - audio_fx_regs.sv
      - audio_fx_effects.sv
      - audio_fx_enhancer.sv
      - audio_fx_streams.sv
      - audio_fx_top.sv
  - target: test
    files:
      - audio_fx_chk.sv
      - audio_fx_tb.sv
